/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Irtl
TOP       ?= controlUnitTb
FILELIST  ?= controlUnit.f
OBJDIR    ?= obj_dir
SIMBIN    := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIMBIN)

$(SIMBIN): $(FILELIST) rtl/*.sv rtl/*.svh sim/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIMBIN)
	@out="$$(./$(SIMBIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJDIR)

/* controlUnit.f */
+incdir+rtl
rtl/controlUnitPkg.sv
rtl/aluFormatDecoder.sv
rtl/wideImmDecoder.sv
rtl/branchDecoder.sv
rtl/decodeControl.sv
rtl/controlUnit.sv
sim/controlUnitTb.sv

/* rtl/aluFormatDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "controlUnit_defines.svh"

module aluFormatDecoder (
	input  wire [`INSTR_W-1:0]        instr,
	output controlUnitPkg::decodeOut_t aluOut
);

	logic [10:0]       op;
	logic [`REG_W-1:0] rd;
	logic [`REG_W-1:0] rn;
	logic [`REG_W-1:0] rm;
	logic              isLoad; // LDUR vs STUR

	assign op     = instr[31:21];
	assign rd     = instr[4:0];
	assign rn     = instr[9:5];
	assign rm     = instr[20:16];
	assign isLoad = instr[22];

	always_comb begin
		aluOut          = '0;
		aluOut.cw.da    = rd;
		aluOut.cw.sa    = rn;
		aluOut.cw.sb    = `REG_XZR;
		aluOut.cw.ps    = controlUnitPkg::pcInc; // all of these just step
		aluOut.cw.pcSrcA = 1'b0;
		aluOut.cw.bus   = controlUnitPkg::busAlu;
		aluOut.movkNext = 1'b0;

		case (op[4:2])
			3'd0: begin
				// D format, address = rn + offset
				aluOut.cw.fs   = controlUnitPkg::opAdd;
				aluOut.cw.sb   = rd; // rt, store data on b
				aluOut.cw.bSel = 1'b0;
				aluOut.k       = `DATA_W'(instr[20:12]);
				if (isLoad) begin
					aluOut.cw.bus      = controlUnitPkg::busRam;
					aluOut.cw.regWrite = 1'b1;
				end else begin
					aluOut.cw.bus      = controlUnitPkg::busB; // rt out to ram
					aluOut.cw.memWrite = 1'b1;
				end
			end
			3'd2: begin
				// addi, addis, subi, subis
				aluOut.cw.fs = instr[30] ? controlUnitPkg::opSub : controlUnitPkg::opAdd;
				aluOut.cw.bSel       = 1'b0; // immediate
				aluOut.cw.statusLoad = instr[29]; // S forms
				aluOut.cw.regWrite   = 1'b1;
				aluOut.k             = `DATA_W'(instr[21:10]);
			end
			3'd4: begin
				// and orr eor ands, register or immediate
				case (instr[30:29])
					2'b00: aluOut.cw.fs = controlUnitPkg::opAnd;
					2'b01: aluOut.cw.fs = controlUnitPkg::opOr;
					2'b10: aluOut.cw.fs = controlUnitPkg::opXor;
					default: begin
						aluOut.cw.fs         = controlUnitPkg::opAnd;
						aluOut.cw.statusLoad = 1'b1; // ands
					end
				endcase
				aluOut.cw.sb       = rm;
				aluOut.cw.bSel     = instr[27]; // set on register form
				aluOut.cw.regWrite = 1'b1;
				aluOut.k = instr[27] ? `DATA_W'(instr[15:10]) : `DATA_W'(instr[21:10]);
			end
			3'd6: begin
				// fs bits: shift, sub, and, or, xor
				aluOut.cw.sb = rm;
				aluOut.cw.fs = controlUnitPkg::aluOp_t'({op[1], op[6], op[1] & ~op[0], 1'b0,
					op[9] & op[6]});
				aluOut.cw.bSel       = ~op[1]; // shifts take shamt from k
				aluOut.cw.statusLoad = (op[9] & op[8]) | (~op[9] & op[8] & op[3]);
				aluOut.cw.regWrite   = 1'b1;
				aluOut.k             = `DATA_W'(instr[15:10]); // shamt
			end
			default: ; // not an alu format, never selected
		endcase
	end

endmodule

`default_nettype wire

/* rtl/branchDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "controlUnit_defines.svh"

module branchDecoder (
	input  wire [`INSTR_W-1:0]          instr,
	input  wire                         zero,   // alu zero, for cbz/cbnz
	input  wire controlUnitPkg::statusFlags_t status, // stored v c z n
	output controlUnitPkg::decodeOut_t  brOut
);

	logic [`DATA_W-1:0] brOff;   // 26 bit offset, B and BL
	logic [`DATA_W-1:0] condOff; // 19 bit offset, cbz and b.cond
	logic               condMet;
	logic               nEqV;    // signed less than

	assign brOff   = {{(`DATA_W-26){instr[25]}}, instr[25:0]};
	assign condOff = {{(`DATA_W-19){instr[23]}}, instr[23:5]};
	assign nEqV    = status.n ^ status.v;

	// arm condition codes on instr[3:0]
	always_comb begin
		case (instr[3:0])
			4'h0: condMet = status.z;                // eq
			4'h1: condMet = ~status.z;               // ne
			4'h2: condMet = status.c;                // hs
			4'h3: condMet = ~status.c;               // lo
			4'h4: condMet = status.n;                // mi
			4'h5: condMet = ~status.n;               // pl
			4'h6: condMet = status.v;                // vs
			4'h7: condMet = ~status.v;               // vc
			4'h8: condMet = status.c & ~status.z;    // hi
			4'h9: condMet = ~status.c | status.z;    // ls
			4'hA: condMet = ~nEqV;                   // ge
			4'hB: condMet = nEqV;                    // lt
			4'hC: condMet = ~status.z & ~nEqV;       // gt
			4'hD: condMet = status.z | nEqV;         // le
			default: condMet = 1'b1;                 // al, nv
		endcase
	end

	always_comb begin
		brOut             = '0;
		brOut.cw.da       = `REG_XZR;
		brOut.cw.sa       = `REG_XZR;
		brOut.cw.sb       = `REG_XZR;
		brOut.cw.fs       = controlUnitPkg::opAnd;
		brOut.cw.ps       = controlUnitPkg::pcInc;
		brOut.cw.bus      = controlUnitPkg::busPc4; // pc+4 on bus for BL
		brOut.cw.regWrite = 1'b0;
		brOut.cw.pcSrcA   = 1'b0; // k into pc unless BR

		case (instr[31:29])
			3'd0: begin // B
				brOut.cw.ps = controlUnitPkg::pcRel;
				brOut.k     = brOff;
			end
			3'd4: begin // BL
				brOut.cw.ps       = controlUnitPkg::pcRel;
				brOut.cw.da       = `REG_LINK;
				brOut.cw.regWrite = 1'b1;
				brOut.k           = brOff;
			end
			3'd6: begin
				// BR, pc <= rn
				brOut.cw.ps     = controlUnitPkg::pcLoad;
				brOut.cw.pcSrcA = 1'b1;
				brOut.cw.sa     = instr[9:5];
				brOut.k         = '0;
			end
			3'd5: begin
				// rt + xzr through alu so zero reflects rt
				brOut.cw.sa   = instr[4:0];
				brOut.cw.sb   = `REG_XZR;
				brOut.cw.fs   = controlUnitPkg::opAdd;
				brOut.cw.bSel = 1'b1;
				brOut.k       = condOff;
				brOut.cw.ps = (instr[24] ^ zero) ? controlUnitPkg::pcRel : controlUnitPkg::pcInc;
			end
			3'd2: begin // b.cond
				brOut.k     = condOff;
				brOut.cw.ps = condMet ? controlUnitPkg::pcRel : controlUnitPkg::pcInc;
			end
			default: ; // not a branch, never selected
		endcase
	end

endmodule

`default_nettype wire

/* rtl/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "controlUnit_defines.svh"

module controlUnit (
	input  wire                         clock,
	input  wire                         arstN,
	input  wire [`INSTR_W-1:0]          instr,   // from rom
	input  wire                         zero,    // alu zero flag
	input  wire controlUnitPkg::statusFlags_t status,
	output controlUnitPkg::ctrlWord_t   controlWord,
	output logic [`DATA_W-1:0]          k        // constant to datapath
);

	controlUnitPkg::decodeOut_t aluOut;
	controlUnitPkg::decodeOut_t iwOut;
	controlUnitPkg::decodeOut_t brOut;
	controlUnitPkg::decodeOut_t selOut;
	logic                       movkPhase;

	aluFormatDecoder aluFormatDecoder_i (
		.instr  (instr),
		.aluOut (aluOut)
	);

	wideImmDecoder wideImmDecoder_i (
		.instr     (instr),
		.movkPhase (movkPhase),
		.iwOut     (iwOut)
	);

	branchDecoder branchDecoder_i (
		.instr  (instr),
		.zero   (zero),
		.status (status),
		.brOut  (brOut)
	);

	// format pick plus movk phase register
	decodeControl decodeControl_i (
		.clock     (clock),
		.arstN     (arstN),
		.instr     (instr),
		.aluOut    (aluOut),
		.iwOut     (iwOut),
		.brOut     (brOut),
		.movkPhase (movkPhase),
		.selOut    (selOut)
	);

	assign controlWord = selOut.cw;
	assign k           = selOut.k;

endmodule

`default_nettype wire

/* rtl/controlUnitPkg.sv */
`default_nettype none

`include "controlUnit_defines.svh"

package controlUnitPkg;

	// fs = {op[2:0], aInvert, bInvert}
	typedef enum logic [4:0] {
		opAnd = 5'b00000,
		opOr  = 5'b00100,
		opAdd = 5'b01000,
		opSub = 5'b01001, // add with b inverted, carry in from bit 0
		opXor = 5'b01100,
		opLsl = 5'b10000,
		opLsr = 5'b10100
	} aluOp_t;

	typedef enum logic [1:0] {
		pcHold = 2'b00, // pc <= pc
		pcInc  = 2'b01, // pc <= pc + 4
		pcLoad = 2'b10, // pc <= in
		pcRel  = 2'b11  // pc <= pc + 4 + in*4
	} pcSel_t;

	// databus driver
	typedef enum logic [1:0] {
		busAlu = 2'b00,
		busRam = 2'b01,
		busPc4 = 2'b10,
		busB   = 2'b11
	} busSel_t;

	// 29 bit word, msb first
	typedef struct packed {
		logic              statusLoad; // latch v c z n
		logic              bSel;       // 0 = k, 1 = register b
		logic              pcSrcA;     // 0 = k, 1 = register a into pc
		logic              memWrite;
		logic              regWrite;
		busSel_t           bus;
		pcSel_t            ps;
		aluOp_t            fs;
		logic [`REG_W-1:0] sb;
		logic [`REG_W-1:0] sa;
		logic [`REG_W-1:0] da;
	} ctrlWord_t;

	typedef struct packed {
		logic v;
		logic c;
		logic z;
		logic n;
	} statusFlags_t;

	// what every format decoder hands back
	typedef struct packed {
		logic               movkNext; // next movk phase
		logic [`DATA_W-1:0] k;
		ctrlWord_t          cw;
	} decodeOut_t;

	typedef enum logic [3:0] {
		fmtNone,
		fmtD,
		fmtIArith,
		fmtLogic,
		fmtIw,
		fmtRAlu,
		fmtB,
		fmtBCond,
		fmtBl,
		fmtCbz,
		fmtBr
	} instrFormat_t;

endpackage

`default_nettype wire

/* rtl/controlUnit_defines.svh */
`ifndef CONTROLUNIT_DEFINES_SVH
`define CONTROLUNIT_DEFINES_SVH

// instruction word coming from rom
`define INSTR_W 32

// constant width, same as datapath width
`define DATA_W 64

// register file index
`define REG_W 5

// zero register, reads as 0 and ignores writes
`define REG_XZR 5'd31

// link register, BL return address lands here
`define REG_LINK 5'd30

`endif

/* rtl/decodeControl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "controlUnit_defines.svh"

module decodeControl (
	input  wire                       clock,
	input  wire                       arstN,
	input  wire [`INSTR_W-1:0]        instr,
	input  wire controlUnitPkg::decodeOut_t aluOut, // d, i arith, logic, r alu
	input  wire controlUnitPkg::decodeOut_t iwOut,  // movz / movk
	input  wire controlUnitPkg::decodeOut_t brOut,  // all branches
	output logic                      movkPhase,
	output controlUnitPkg::decodeOut_t selOut
);

	logic [10:0] op; // 11 bit opcode, narrower formats just see more bits
	controlUnitPkg::instrFormat_t fmt;

	assign op = instr[31:21];

	// op[5] splits branches from everything else
	always_comb begin
		fmt = controlUnitPkg::fmtNone;
		if (op[5]) begin
			case (op[10:8])
				3'd0: fmt = controlUnitPkg::fmtB;
				3'd2: fmt = controlUnitPkg::fmtBCond;
				3'd4: fmt = controlUnitPkg::fmtBl;
				3'd5: fmt = controlUnitPkg::fmtCbz; // cbz and cbnz
				3'd6: fmt = controlUnitPkg::fmtBr;
				default: fmt = controlUnitPkg::fmtNone;
			endcase
		end else begin
			case (op[4:2])
				3'd0: fmt = controlUnitPkg::fmtD;
				3'd2: fmt = controlUnitPkg::fmtIArith;
				3'd4: fmt = controlUnitPkg::fmtLogic; // reg and imm forms
				3'd5: fmt = controlUnitPkg::fmtIw;
				3'd6: fmt = controlUnitPkg::fmtRAlu;
				default: fmt = controlUnitPkg::fmtNone;
			endcase
		end
	end

	always_comb begin
		case (fmt)
			controlUnitPkg::fmtD,
			controlUnitPkg::fmtIArith,
			controlUnitPkg::fmtLogic,
			controlUnitPkg::fmtRAlu:  selOut = aluOut;
			controlUnitPkg::fmtIw:    selOut = iwOut;
			controlUnitPkg::fmtB,
			controlUnitPkg::fmtBCond,
			controlUnitPkg::fmtBl,
			controlUnitPkg::fmtCbz,
			controlUnitPkg::fmtBr:    selOut = brOut;
			default:                  selOut = '0; // nop, pc held, no writes
		endcase
	end

	// movk phase, only state in the decoder
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			movkPhase <= 1'b0;
		else
			movkPhase <= selOut.movkNext;
	end

endmodule

`default_nettype wire

/* rtl/wideImmDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "controlUnit_defines.svh"

module wideImmDecoder (
	input  wire [`INSTR_W-1:0]        instr,
	input  wire                       movkPhase, // 1 in second movk cycle
	output controlUnitPkg::decodeOut_t iwOut
);

	logic               isMovk;
	logic [1:0]         hw;       // 16 bit lane select
	logic [5:0]         laneShift;
	logic [`DATA_W-1:0] laneVal;  // imm16 placed in lane
	logic [`DATA_W-1:0] laneMask; // clears lane, keeps the rest

	assign isMovk    = instr[29];
	assign hw        = instr[22:21];
	assign laneShift = {hw, 4'b0000};
	assign laneVal   = `DATA_W'(instr[20:5]) << laneShift;
	assign laneMask  = ~(`DATA_W'(16'hFFFF) << laneShift);

	always_comb begin
		iwOut             = '0;
		iwOut.cw.da       = instr[4:0];
		iwOut.cw.sb       = `REG_XZR;
		iwOut.cw.bSel     = 1'b0; // k on b input
		iwOut.cw.bus      = controlUnitPkg::busAlu;
		iwOut.cw.regWrite = 1'b1;

		if (!isMovk) begin
			// movz, xzr | lane value, done in one go
			iwOut.cw.fs = controlUnitPkg::opOr;
			iwOut.cw.sa = `REG_XZR;
			iwOut.cw.ps = controlUnitPkg::pcInc;
			iwOut.k     = laneVal;
		end else if (!movkPhase) begin
			// first movk cycle, knock out the lane
			iwOut.cw.fs    = controlUnitPkg::opAnd;
			iwOut.cw.sa    = instr[4:0]; // rd read back
			iwOut.cw.ps    = controlUnitPkg::pcHold; // same instr again next cycle
			iwOut.k        = laneMask;
			iwOut.movkNext = 1'b1;
		end else begin
			// second cycle, or the new bits in
			iwOut.cw.fs    = controlUnitPkg::opOr;
			iwOut.cw.sa    = instr[4:0];
			iwOut.cw.ps    = controlUnitPkg::pcInc;
			iwOut.k        = laneVal;
			iwOut.movkNext = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* sim/controlUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "controlUnit_defines.svh"

module controlUnitTb;

	localparam int MAX_ENTRIES = 64;
	localparam int TIMEOUT_CYCLES = 5000;

	logic                         clock;
	logic                         arstN;
	logic [`INSTR_W-1:0]          instr;
	logic                         zero;
	controlUnitPkg::statusFlags_t status;
	controlUnitPkg::ctrlWord_t    controlWord;
	logic [`DATA_W-1:0]           k;

	// stimulus / expected table
	string                     tabName   [MAX_ENTRIES];
	logic [`INSTR_W-1:0]       tabInstr  [MAX_ENTRIES];
	logic                      tabZero   [MAX_ENTRIES];
	logic [3:0]                tabStatus [MAX_ENTRIES]; // {v, c, z, n}
	controlUnitPkg::ctrlWord_t tabWord   [MAX_ENTRIES];
	logic [`DATA_W-1:0]        tabK      [MAX_ENTRIES];
	int numEntries = 0;
	int wordErrors = 0;
	int kErrors    = 0;

	controlUnit controlUnit_i (
		.clock       (clock),
		.arstN       (arstN),
		.instr       (instr),
		.zero        (zero),
		.status      (status),
		.controlWord (controlWord),
		.k           (k)
	);

	initial clock = 1'b0;
	always #4 clock = ~clock; // 8 ns period

	function automatic controlUnitPkg::ctrlWord_t makeWord(input logic sl, input logic bs,
		input logic pa, input logic mw, input logic rw, input controlUnitPkg::busSel_t bus,
		input controlUnitPkg::pcSel_t ps, input controlUnitPkg::aluOp_t fs,
		input logic [4:0] sb, input logic [4:0] sa, input logic [4:0] da);
		controlUnitPkg::ctrlWord_t w;
		w.statusLoad = sl;
		w.bSel       = bs;
		w.pcSrcA     = pa;
		w.memWrite   = mw;
		w.regWrite   = rw;
		w.bus        = bus;
		w.ps         = ps;
		w.fs         = fs;
		w.sb         = sb;
		w.sa         = sa;
		w.da         = da;
		return w;
	endfunction

	// arm condition list, st = {v, c, z, n}
	function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] st);
		logic v, c, z, n;
		v = st[3];
		c = st[2];
		z = st[1];
		n = st[0];
		case (cond)
			4'h0: return z;
			4'h1: return !z;
			4'h2: return c;
			4'h3: return !c;
			4'h4: return n;
			4'h5: return !n;
			4'h6: return v;
			4'h7: return !v;
			4'h8: return c && !z;
			4'h9: return !c || z;
			4'hA: return n == v;
			4'hB: return n != v;
			4'hC: return !z && (n == v);
			4'hD: return z || (n != v);
			default: return 1'b1; // al, nv
		endcase
	endfunction

	// imm16 dropped into its 16 bit lane
	function automatic logic [63:0] laneValue(input logic [15:0] imm, input logic [1:0] hw);
		case (hw)
			2'd0: return {48'h0, imm};
			2'd1: return {32'h0, imm, 16'h0};
			2'd2: return {16'h0, imm, 32'h0};
			default: return {imm, 48'h0};
		endcase
	endfunction

	// ones everywhere except the selected lane
	function automatic logic [63:0] laneMask(input logic [1:0] hw);
		case (hw)
			2'd0: return 64'hFFFF_FFFF_FFFF_0000;
			2'd1: return 64'hFFFF_FFFF_0000_FFFF;
			2'd2: return 64'hFFFF_0000_FFFF_FFFF;
			default: return 64'h0000_FFFF_FFFF_FFFF;
		endcase
	endfunction

	task automatic addEntry(input string name, input logic [31:0] ins, input logic z,
		input logic [3:0] st, input controlUnitPkg::ctrlWord_t w, input logic [63:0] kv);
		tabName[numEntries]   = name;
		tabInstr[numEntries]  = ins;
		tabZero[numEntries]   = z;
		tabStatus[numEntries] = st;
		tabWord[numEntries]   = w;
		tabK[numEntries]      = kv;
		numEntries++;
	endtask

	// two rows, same instr held, mask then or
	task automatic addMovk(input logic [1:0] hw, input logic [15:0] imm, input logic [4:0] rd);
		logic [31:0] ins;
		ins = 32'hF2800000 | ({30'h0, hw} << 21) | ({16'h0, imm} << 5) | {27'h0, rd};
		addEntry($sformatf("movk hw%0d phase0", hw), ins, 1'b0, 4'h0,
			makeWord(0, 0, 0, 0, 1, controlUnitPkg::busAlu, controlUnitPkg::pcHold,
				controlUnitPkg::opAnd, 5'd31, rd, rd), laneMask(hw));
		addEntry($sformatf("movk hw%0d phase1", hw), ins, 1'b0, 4'h0,
			makeWord(0, 0, 0, 0, 1, controlUnitPkg::busAlu, controlUnitPkg::pcInc,
				controlUnitPkg::opOr, 5'd31, rd, rd), laneValue(imm, hw));
	endtask

	task automatic buildTable();
		logic [31:0] ins;
		logic [18:0] imm19;
		logic [15:0] imm16;
		logic [3:0]  st;
		controlUnitPkg::pcSel_t ps;
		// movk first so it starts straight out of reset
		for (int h = 0; h < 4; h++) addMovk(h[1:0], 16'($urandom), 5'(h + 1));
		for (int h = 0; h < 4; h++) begin
			imm16 = 16'($urandom);
			ins = 32'hD2800000 | (h << 21) | ({16'h0, imm16} << 5) | 32'd9;
			addEntry($sformatf("movz hw%0d", h), ins, 1'b0, 4'h0,
				makeWord(0, 0, 0, 0, 1, controlUnitPkg::busAlu, controlUnitPkg::pcInc,
					controlUnitPkg::opOr, 5'd31, 5'd31, 5'd9), laneValue(imm16, h[1:0]));
		end
		addMovk(2'd2, 16'hBEEF, 5'd20); // phase back at 0 after movz
		addEntry("addi", 32'h91001441, 0, 0, makeWord(0, 0, 0, 0, 1, controlUnitPkg::busAlu,
			controlUnitPkg::pcInc, controlUnitPkg::opAdd, 31, 2, 1), 64'd5);
		addEntry("subis", 32'hF13FFC83, 0, 0, makeWord(1, 0, 0, 0, 1, controlUnitPkg::busAlu,
			controlUnitPkg::pcInc, controlUnitPkg::opSub, 31, 4, 3), 64'hFFF);
		addEntry("andi", 32'h9202ACC5, 0, 0, makeWord(0, 0, 0, 0, 1, controlUnitPkg::busAlu,
			controlUnitPkg::pcInc, controlUnitPkg::opAnd, 2, 6, 5), 64'hAB);
		addEntry("eor reg", 32'hCA090107, 0, 0, makeWord(0, 1, 0, 0, 1, controlUnitPkg::busAlu,
			controlUnitPkg::pcInc, controlUnitPkg::opXor, 9, 8, 7), 64'd0);
		addEntry("orri", 32'hB20FC16A, 0, 0, makeWord(0, 0, 0, 0, 1, controlUnitPkg::busAlu,
			controlUnitPkg::pcInc, controlUnitPkg::opOr, 15, 11, 10), 64'h3F0);
		addEntry("lsl", 32'hD36011AC, 0, 0, makeWord(0, 0, 0, 0, 1, controlUnitPkg::busAlu,
			controlUnitPkg::pcInc, controlUnitPkg::opLsl, 0, 13, 12), 64'd4);
		addEntry("ldur", 32'hF84081EE, 0, 0, makeWord(0, 0, 0, 0, 1, controlUnitPkg::busRam,
			controlUnitPkg::pcInc, controlUnitPkg::opAdd, 14, 15, 14), 64'd8);
		addEntry("stur", 32'hF81FF230, 0, 0, makeWord(0, 0, 0, 1, 0, controlUnitPkg::busB,
			controlUnitPkg::pcInc, controlUnitPkg::opAdd, 16, 17, 16), 64'h1FF);
		addEntry("b fwd", 32'h14000064, 0, 0, makeWord(0, 0, 0, 0, 0, controlUnitPkg::busPc4,
			controlUnitPkg::pcRel, controlUnitPkg::opAnd, 31, 31, 31), 64'd100);
		addEntry("b back", 32'h17FFFFFC, 0, 0, makeWord(0, 0, 0, 0, 0, controlUnitPkg::busPc4,
			controlUnitPkg::pcRel, controlUnitPkg::opAnd, 31, 31, 31), -64'sd4);
		addEntry("bl fwd", 32'h94000008, 0, 0, makeWord(0, 0, 0, 0, 1, controlUnitPkg::busPc4,
			controlUnitPkg::pcRel, controlUnitPkg::opAnd, 31, 31, 30), 64'd8);
		addEntry("bl back", 32'h97FFFFFE, 0, 0, makeWord(0, 0, 0, 0, 1, controlUnitPkg::busPc4,
			controlUnitPkg::pcRel, controlUnitPkg::opAnd, 31, 31, 30), -64'sd2);
		addEntry("br", 32'hD60003C0, 0, 0, makeWord(0, 0, 1, 0, 0, controlUnitPkg::busPc4,
			controlUnitPkg::pcLoad, controlUnitPkg::opAnd, 31, 30, 31), 64'd0);
		for (int z = 0; z < 2; z++) begin
			// cbz taken on zero, cbnz taken when not zero
			ps = z ? controlUnitPkg::pcRel : controlUnitPkg::pcInc;
			addEntry($sformatf("cbz zero%0d", z), 32'hB4000203, z[0], 0,
				makeWord(0, 1, 0, 0, 0, controlUnitPkg::busPc4, ps, controlUnitPkg::opAdd,
					31, 3, 31), 64'd16);
			ps = z ? controlUnitPkg::pcInc : controlUnitPkg::pcRel;
			addEntry($sformatf("cbnz zero%0d", z), 32'hB5FFFFE4, z[0], 0,
				makeWord(0, 1, 0, 0, 0, controlUnitPkg::busPc4, ps, controlUnitPkg::opAdd,
					31, 4, 31), -64'sd1);
		end
		for (int c = 0; c < 16; c++) begin
			st    = 4'($urandom);
			imm19 = 19'($urandom);
			ins   = 32'h54000000 | ({13'h0, imm19} << 5) | c;
			ps    = condHolds(c[3:0], st) ? controlUnitPkg::pcRel : controlUnitPkg::pcInc;
			addEntry($sformatf("bcond %0d", c), ins, 1'b0, st,
				makeWord(0, 0, 0, 0, 0, controlUnitPkg::busPc4, ps, controlUnitPkg::opAnd,
					31, 31, 31), {{45{imm19[18]}}, imm19});
		end
		addEntry("unused op", 32'h00800000, 0, 0, '0, 64'd0); // nop word
	endtask

	initial begin
		void'($urandom(32'h1ba32b32));
		arstN  = 1'b0;
		instr  = '0;
		zero   = 1'b0;
		status = '0;
		buildTable();
		repeat (8) @(posedge clock);
		arstN <= 1'b1;
		for (int i = 0; i < numEntries; i++) begin
			@(posedge clock);
			instr  <= tabInstr[i];
			zero   <= tabZero[i];
			status <= tabStatus[i];
			@(negedge clock); // outputs settled mid cycle
			assert (controlWord === tabWord[i]) else begin
				wordErrors++;
				$display("FAILED %s: controlWord expected %h actual %h",
					tabName[i], tabWord[i], controlWord);
			end
			assert (k === tabK[i]) else begin
				kErrors++;
				$display("FAILED %s: k expected %h actual %h", tabName[i], tabK[i], k);
			end
		end
		$display("errors: controlWord %0d, k %0d", wordErrors, kErrors);
		if (wordErrors + kErrors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// watchdog in case the run stalls
	initial begin
		for (int t = 0; t < TIMEOUT_CYCLES; t++) @(posedge clock);
		$display("timeout, the table run did not finish");
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
